/* hdl/console_io_pkg.sv */
//--------------------------------------------------------------------------
// Console I/O shared definitions
// Word widths, pad and joypad word types, driver bit positions and the
// pointer step sizes
//--------------------------------------------------------------------------

package console_io_pkg;

    localparam int PAD_W    = 16;
    localparam int JOY_W    = 12;
    localparam int COORD_W  = 8;
    localparam int SAMPLE_W = 16;
    localparam int LEVEL_W  = 15;

    typedef logic [PAD_W-1:0]           pad_word_t;  // Active low, driver order
    typedef logic [JOY_W-1:0]           joy_word_t;  // B Y Sel Start U D L R A X L R
    typedef logic [COORD_W-1:0]         coord_t;     // Wraps modulo 256
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [LEVEL_W-1:0]         level_t;     // Magnitude or offset binary

    // Button positions in the raw pad word
    localparam int PAD_B      = 14;
    localparam int PAD_Y      = 15;
    localparam int PAD_SELECT = 0;
    localparam int PAD_START  = 3;
    localparam int PAD_UP     = 4;
    localparam int PAD_DOWN   = 6;
    localparam int PAD_LEFT   = 7;
    localparam int PAD_RIGHT  = 5;
    localparam int PAD_A      = 13;
    localparam int PAD_X      = 12;
    localparam int PAD_L      = 10;
    localparam int PAD_R      = 11;

    // L2 R2 L1 R1 together
    localparam int PAD_SHOULDERS_LO = 8;
    localparam int PAD_SHOULDERS_HI = 11;

    localparam coord_t FINE_STEP   = coord_t'(1);
    localparam coord_t COARSE_STEP = coord_t'(10);

endpackage

/* hdl/pwm_timer.sv */
//--------------------------------------------------------------------------
// PWM timer
// Free-running counter giving a low-duty pulse for LED dimming
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pwm_timer #(
    parameter int DIM_W    = 8,
    parameter int DIM_DUTY = 1
) (
    input  logic clk,
    input  logic reset,
    output logic dim_pulse
);

    logic [DIM_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;     // Wraps every 2^DIM_W cycles
        end
    end

    assign dim_pulse = (count < DIM_W'(DIM_DUTY));

endmodule

/* hdl/pad_router.sv */
//--------------------------------------------------------------------------
// Pad router
// Captures both pad words, applies the player swap, remaps them to
// joypad words and drives the status LEDs and the shoulder reset request
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pad_router
    import console_io_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pad_strobe,
    input  pad_word_t p1_pad,
    input  pad_word_t p2_pad,
    input  logic      p1_connect,
    input  logic      p2_connect,
    input  logic      pad_swap,
    input  logic      dim_pulse,
    output joy_word_t joy1,
    output joy_word_t joy2,
    output logic      pad_reset_req,
    output logic      led_p1,
    output logic      led_p2
);

    pad_word_t p1_q;
    pad_word_t p2_q;
    logic      p1_connected;
    logic      p2_connected;

    // Invert and reorder one raw pad word
    function automatic joy_word_t remap(pad_word_t pad);
        return ~{pad[PAD_B], pad[PAD_Y], pad[PAD_SELECT], pad[PAD_START],
                 pad[PAD_UP], pad[PAD_DOWN], pad[PAD_LEFT], pad[PAD_RIGHT],
                 pad[PAD_A], pad[PAD_X], pad[PAD_L], pad[PAD_R]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            p1_q         <= '1;       // All released
            p2_q         <= '1;
            p1_connected <= 1'b0;
            p2_connected <= 1'b0;
        end else if (pad_strobe) begin
            p1_q         <= pad_swap ? p2_pad : p1_pad;
            p2_q         <= pad_swap ? p1_pad : p2_pad;
            p1_connected <= pad_swap ? p2_connect : p1_connect;
            p2_connected <= pad_swap ? p1_connect : p2_connect;
        end
    end

    assign joy1 = remap(p1_q);
    assign joy2 = remap(p2_q);

    assign pad_reset_req = (p1_q[PAD_SHOULDERS_HI:PAD_SHOULDERS_LO] == '0);

    // Full on while a button is held, dimmed while idle
    assign led_p1 = p1_connected & ((|joy1) | dim_pulse);
    assign led_p2 = p2_connected & ((|joy2) | dim_pulse);

endmodule

/* hdl/coord_pointer.sv */
//--------------------------------------------------------------------------
// Debug coordinate pointer
// Steps x and y on rising player-1 D-pad edges and hides player 1
// from the console while the pointer is active
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module coord_pointer
    import console_io_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  joy_word_t joy1,
    input  logic      pointer_en,
    input  logic      pointer_coarse,
    output joy_word_t console_joy1,
    output coord_t    pointer_x,
    output coord_t    pointer_y
);

    // D-pad field of the joypad word, Up down to Right
    localparam int JOY_DPAD_HI = 7;
    localparam int JOY_DPAD_LO = 4;

    logic [3:0] dpad;           // [0] Right [1] Left [2] Down [3] Up
    logic [3:0] dpad_q;
    logic [3:0] dpad_rise;
    coord_t     step;

    assign dpad      = joy1[JOY_DPAD_HI:JOY_DPAD_LO];
    assign dpad_rise = dpad & ~dpad_q;
    assign step      = pointer_coarse ? COARSE_STEP : FINE_STEP;

    assign console_joy1 = pointer_en ? '0 : joy1;

    always_ff @(posedge clk) begin
        if (reset) begin
            dpad_q    <= '0;
            pointer_x <= '0;
            pointer_y <= '0;
        end else begin
            dpad_q <= dpad;
            if (pointer_en) begin
                if (dpad_rise[0]) begin            // Right wins over Left
                    pointer_x <= pointer_x + step;
                end else if (dpad_rise[1]) begin
                    pointer_x <= pointer_x - step;
                end

                if (dpad_rise[2]) begin            // Down wins over Up
                    pointer_y <= pointer_y + step;
                end else if (dpad_rise[3]) begin
                    pointer_y <= pointer_y - step;
                end
            end
        end
    end

    a_hold_when_disabled : assert property (
        @(posedge clk) disable iff (reset)
        !pointer_en |=> $stable(pointer_x) && $stable(pointer_y)
    );

endmodule

/* hdl/peak_meter.sv */
//--------------------------------------------------------------------------
// Stereo peak meter
// Holds the largest sample magnitude of either channel since the
// last reset or clear
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module peak_meter
    import console_io_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    clear,
    input  logic    sample_strobe,
    input  sample_t sound_l,
    input  sample_t sound_r,
    output level_t  peak
);

    level_t mag_l;
    level_t mag_r;
    level_t mag_max;

    function automatic level_t magnitude(sample_t s);
        sample_t neg;
        neg = -s;
        return s[SAMPLE_W-1] ? neg[LEVEL_W-1:0] : s[LEVEL_W-1:0];
    endfunction

    assign mag_l   = magnitude(sound_l);
    assign mag_r   = magnitude(sound_r);
    assign mag_max = (mag_l > mag_r) ? mag_l : mag_r;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            peak <= '0;
        end else if (sample_strobe && (mag_max > peak)) begin
            peak <= mag_max;
        end
    end

    // Only reset or clear brings the level down
    a_peak_monotonic : assert property (
        @(posedge clk) disable iff (reset)
        !clear |=> peak >= $past(peak)
    );

endmodule

/* hdl/pdm_dac.sv */
//--------------------------------------------------------------------------
// First-order delta-sigma DAC
// Turns one signed audio channel into a pulse-density stream
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pdm_dac
    import console_io_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  sample_t sample,
    output logic    pdm
);

    level_t           level;
    level_t           acc;
    logic [LEVEL_W:0] sum;     // Carry out is the next pulse

    // -4000h..3FFFh becomes 0..7FFFh
    assign level = {~sample[LEVEL_W-1], sample[LEVEL_W-2:0]};
    assign sum   = {1'b0, acc} + {1'b0, level};

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            pdm <= 1'b0;
        end else begin
            acc <= sum[LEVEL_W-1:0];
            pdm <= sum[LEVEL_W];
        end
    end

endmodule

/* hdl/console_io_top.sv */
//--------------------------------------------------------------------------
// Console I/O top level
// Pad routing, debug pointer, LED dimming, peak meter and stereo DACs
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module console_io_top
    import console_io_pkg::*;
#(
    parameter int DIM_W    = 8,
    parameter int DIM_DUTY = 1
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      pad_strobe,
    input  pad_word_t p1_pad,
    input  pad_word_t p2_pad,
    input  logic      p1_connect,
    input  logic      p2_connect,
    input  logic      pad_swap,
    input  logic      pointer_en,
    input  logic      pointer_coarse,
    input  logic      sample_strobe,
    input  sample_t   sound_l,
    input  sample_t   sound_r,
    output joy_word_t console_joy1,
    output joy_word_t joy2,
    output coord_t    pointer_x,
    output coord_t    pointer_y,
    output logic      pad_reset_req,
    output logic      led_p1,
    output logic      led_p2,
    output level_t    peak,
    output logic      pdm_l,
    output logic      pdm_r
);

    joy_word_t joy1;          // Player 1 before pointer masking
    logic      dim_pulse;

    //--------------------------------------------------------------------------
    // Pad path
    //--------------------------------------------------------------------------

    pwm_timer #(
        .DIM_W    (DIM_W),
        .DIM_DUTY (DIM_DUTY)
    ) pwm_timer_inst (
        .clk       (clk),
        .reset     (reset),
        .dim_pulse (dim_pulse)
    );

    pad_router pad_router_inst (
        .clk           (clk),
        .reset         (reset),
        .pad_strobe    (pad_strobe),
        .p1_pad        (p1_pad),
        .p2_pad        (p2_pad),
        .p1_connect    (p1_connect),
        .p2_connect    (p2_connect),
        .pad_swap      (pad_swap),
        .dim_pulse     (dim_pulse),
        .joy1          (joy1),
        .joy2          (joy2),
        .pad_reset_req (pad_reset_req),
        .led_p1        (led_p1),
        .led_p2        (led_p2)
    );

    coord_pointer coord_pointer_inst (
        .clk            (clk),
        .reset          (reset),
        .joy1           (joy1),
        .pointer_en     (pointer_en),
        .pointer_coarse (pointer_coarse),
        .console_joy1   (console_joy1),
        .pointer_x      (pointer_x),
        .pointer_y      (pointer_y)
    );

    //--------------------------------------------------------------------------
    // Audio path
    //--------------------------------------------------------------------------

    peak_meter peak_meter_inst (
        .clk           (clk),
        .reset         (reset),
        .clear         (pad_reset_req),    // Shoulder combo also clears the meter
        .sample_strobe (sample_strobe),
        .sound_l       (sound_l),
        .sound_r       (sound_r),
        .peak          (peak)
    );

    pdm_dac pdm_dac_l_inst (
        .clk    (clk),
        .reset  (reset),
        .sample (sound_l),
        .pdm    (pdm_l)
    );

    pdm_dac pdm_dac_r_inst (
        .clk    (clk),
        .reset  (reset),
        .sample (sound_r),
        .pdm    (pdm_r)
    );

endmodule

/* tests/tb_checks.svh */
//--------------------------------------------------------------------------
// Testbench checks
// Typed compare tasks, per-test error count and pass/fail totals
//--------------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int tests_passed = 0;
int tests_failed = 0;
int test_errors  = 0;      // Errors in the running test

task automatic check_joy(string name, joy_word_t expected, joy_word_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h actual %h", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_coord(string name, coord_t expected, coord_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected %0d actual %0d", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_level(string name, level_t expected, level_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected %0d actual %0d", name, expected, actual);
        test_errors++;
    end
endtask

// Single flags are compared here too, as 0 or 1
task automatic check_count(string name, int expected, int actual);
    if (actual !== expected) begin
        $display("ERR %s expected %0d actual %0d", name, expected, actual);
        test_errors++;
    end
endtask

task automatic finish_test(string name);
    if (test_errors == 0) begin
        $display("PASS %s", name);
        tests_passed++;
    end else begin
        $display("FAIL %s with %0d errors", name, test_errors);
        tests_failed++;
    end
    test_errors = 0;
endtask

`endif

/* tests/tb_console_io.sv */
//--------------------------------------------------------------------------
// Console I/O testbench
// Table-driven tests of pad routing, pointer, peak meter, DACs and LEDs
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_console_io
    import console_io_pkg::*;
();

    localparam int DIM_W      = 8;
    localparam int DIM_DUTY   = 1;
    localparam int LED_PERIOD = 2 ** DIM_W;
    localparam int DAC_CYCLES = 2 ** LEVEL_W;

    // Source bit in the pad word for each joypad bit, B first
    localparam logic [4*JOY_W-1:0] JOY_SRC = {
        4'(PAD_B), 4'(PAD_Y), 4'(PAD_SELECT), 4'(PAD_START), 4'(PAD_UP), 4'(PAD_DOWN),
        4'(PAD_LEFT), 4'(PAD_RIGHT), 4'(PAD_A), 4'(PAD_X), 4'(PAD_L), 4'(PAD_R)};

    // Table rows, fields in declaration order
    typedef struct packed {
        pad_word_t p1;
        pad_word_t p2;
        logic      swap;
        joy_word_t exp_joy1;
        joy_word_t exp_joy2;
        logic      exp_req;
    } remap_row_t;

    typedef struct packed {
        logic [3:0] press;      // [0] Right [1] Left [2] Down [3] Up
        logic       coarse;
        coord_t     x;
        coord_t     y;
    } pointer_row_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
        level_t  peak;
    } peak_row_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
        int      level_l;
        int      level_r;
    } dac_row_t;

    typedef struct packed {
        logic c1;
        logic press1;
        logic c2;
        logic press2;
        int   count1;
        int   count2;
    } led_row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        pad_strobe;
    pad_word_t   p1_pad;
    pad_word_t   p2_pad;
    logic        p1_connect;
    logic        p2_connect;
    logic        pad_swap;
    logic        pointer_en;
    logic        pointer_coarse;
    logic        sample_strobe;
    sample_t     sound_l;
    sample_t     sound_r;
    joy_word_t   console_joy1;
    joy_word_t   joy2;
    coord_t      pointer_x;
    coord_t      pointer_y;
    logic        pad_reset_req;
    logic        led_p1;
    logic        led_p2;
    level_t      peak;
    logic        pdm_l;
    logic        pdm_r;
    logic [31:0] rng_state = 32'd23;

    `include "tb_checks.svh"

    console_io_top #(
        .DIM_W    (DIM_W),
        .DIM_DUTY (DIM_DUTY)
    ) console_io_top_inst (
        .clk            (clk),
        .reset          (reset),
        .pad_strobe     (pad_strobe),
        .p1_pad         (p1_pad),
        .p2_pad         (p2_pad),
        .p1_connect     (p1_connect),
        .p2_connect     (p2_connect),
        .pad_swap       (pad_swap),
        .pointer_en     (pointer_en),
        .pointer_coarse (pointer_coarse),
        .sample_strobe  (sample_strobe),
        .sound_l        (sound_l),
        .sound_r        (sound_r),
        .console_joy1   (console_joy1),
        .joy2           (joy2),
        .pointer_x      (pointer_x),
        .pointer_y      (pointer_y),
        .pad_reset_req  (pad_reset_req),
        .led_p1         (led_p1),
        .led_p2         (led_p2),
        .peak           (peak),
        .pdm_l          (pdm_l),
        .pdm_r          (pdm_r)
    );

    always #5 clk = ~clk;

    //--------------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Active-low pad word to active-high joypad word
    function automatic joy_word_t expected_joy(pad_word_t pad);
        joy_word_t joy;
        for (int k = 0; k < JOY_W; k++) begin
            joy[k] = ~pad[JOY_SRC[4*k +: 4]];
        end
        return joy;
    endfunction

    function automatic pad_word_t dpad_word(logic [3:0] press);
        pad_word_t pad;
        pad             = '1;
        pad[PAD_RIGHT]  = ~press[0];
        pad[PAD_LEFT]   = ~press[1];
        pad[PAD_DOWN]   = ~press[2];
        pad[PAD_UP]     = ~press[3];
        return pad;
    endfunction

    task automatic run_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        run_cycles(16);
        reset = 1'b0;
    endtask

    // Called on a falling edge, returns one cycle after the strobe
    task automatic strobe_pads(pad_word_t pad_a, pad_word_t pad_b, logic conn_a,
                               logic conn_b, logic swap);
        p1_pad     = pad_a;
        p2_pad     = pad_b;
        p1_connect = conn_a;
        p2_connect = conn_b;
        pad_swap   = swap;
        pad_strobe = 1'b1;
        @(negedge clk);
        pad_strobe = 1'b0;
    endtask

    task automatic strobe_samples(sample_t l, sample_t r);
        sound_l       = l;
        sound_r       = r;
        sample_strobe = 1'b1;
        @(negedge clk);
        sample_strobe = 1'b0;
    endtask

    //--------------------------------------------------------------------------
    // Tests
    //--------------------------------------------------------------------------

    task automatic test_remap();
        remap_row_t table_q[$];
        remap_row_t row;
        pad_word_t  sel1;
        string      name;
        for (int i = 0; i < 9; i++) begin
            rng_state = xorshift32(rng_state);
            row.p1    = rng_state[15:0];
            row.p2    = rng_state[31:16];
            row.swap  = i[0];
            if (i == 6) row.p1 = row.p1 & 16'hF0FF;   // Shoulder combo, no swap
            if (i == 7) row.p2 = row.p2 & 16'hF0FF;   // Shoulder combo via swap
            if (i == 8) begin                         // All released again
                row.p1 = '1;
                row.p2 = '1;
            end
            sel1         = row.swap ? row.p2 : row.p1;
            row.exp_joy1 = expected_joy(sel1);
            row.exp_joy2 = expected_joy(row.swap ? row.p1 : row.p2);
            row.exp_req  = (sel1[PAD_SHOULDERS_HI:PAD_SHOULDERS_LO] == 4'h0);
            table_q.push_back(row);
        end
        foreach (table_q[i]) begin
            row  = table_q[i];
            name = $sformatf("remap[%0d]", i);
            if (row.exp_req) begin
                // Drop any held combo so the meter holds a level to clear
                strobe_pads('1, '1, 1'b1, 1'b1, 1'b0);
                strobe_samples(16'sd1234, -16'sd77);
            end
            strobe_pads(row.p1, row.p2, 1'b1, 1'b1, row.swap);
            check_joy({name, " joy1"}, row.exp_joy1, console_joy1);
            check_joy({name, " joy2"}, row.exp_joy2, joy2);
            check_count({name, " reset_req"}, int'(row.exp_req), int'(pad_reset_req));
            if (row.exp_req) begin
                run_cycles(1);
                check_level({name, " peak"}, '0, peak);
            end
        end
        finish_test("remap_swap_combo");
    endtask

    task automatic test_pointer();
        pointer_row_t table_q[$];
        string        name;
        table_q.push_back({4'b0001, 1'b0, 8'd1,   8'd0});
        table_q.push_back({4'b0001, 1'b0, 8'd1,   8'd0});     // Held, no step
        table_q.push_back({4'b0000, 1'b0, 8'd1,   8'd0});
        table_q.push_back({4'b0001, 1'b1, 8'd11,  8'd0});
        table_q.push_back({4'b0000, 1'b1, 8'd11,  8'd0});
        table_q.push_back({4'b0010, 1'b0, 8'd10,  8'd0});
        table_q.push_back({4'b0000, 1'b0, 8'd10,  8'd0});
        table_q.push_back({4'b0010, 1'b1, 8'd0,   8'd0});
        table_q.push_back({4'b0000, 1'b0, 8'd0,   8'd0});
        table_q.push_back({4'b0010, 1'b0, 8'd255, 8'd0});     // Wraps below zero
        table_q.push_back({4'b0000, 1'b0, 8'd255, 8'd0});
        table_q.push_back({4'b1000, 1'b1, 8'd255, 8'd246});
        table_q.push_back({4'b0011, 1'b0, 8'd0,   8'd246});   // Right beats Left
        table_q.push_back({4'b0000, 1'b0, 8'd0,   8'd246});
        table_q.push_back({4'b0100, 1'b1, 8'd0,   8'd0});
        table_q.push_back({4'b1100, 1'b0, 8'd0,   8'd255});   // Only Up rises
        table_q.push_back({4'b0000, 1'b0, 8'd0,   8'd255});
        table_q.push_back({4'b0101, 1'b1, 8'd10,  8'd9});
        pointer_en = 1'b1;
        foreach (table_q[i]) begin
            name           = $sformatf("pointer[%0d]", i);
            pointer_coarse = table_q[i].coarse;
            strobe_pads(dpad_word(table_q[i].press), '1, 1'b1, 1'b1, 1'b0);
            run_cycles(1);                            // Step lands one cycle later
            check_coord({name, " x"}, table_q[i].x, pointer_x);
            check_coord({name, " y"}, table_q[i].y, pointer_y);
            check_joy({name, " console_joy1"}, '0, console_joy1);
        end
        pointer_en     = 1'b0;
        pointer_coarse = 1'b0;
        finish_test("pointer");
    endtask

    task automatic test_peak();
        peak_row_t table_q[$];
        table_q.push_back({16'sd100,    -16'sd50,    15'd100});
        table_q.push_back({-16'sd300,   16'sd200,    15'd300});
        table_q.push_back({16'sd50,     16'sd60,     15'd300});
        table_q.push_back({16'sd0,      -16'sd4000,  15'd4000});
        table_q.push_back({16'sd12000,  -16'sd11999, 15'd12000});
        table_q.push_back({-16'sd16383, 16'sd5,      15'd16383});
        table_q.push_back({16'sd16383,  16'sd16383,  15'd16383});
        apply_reset();
        foreach (table_q[i]) begin
            strobe_samples(table_q[i].l, table_q[i].r);
            check_level($sformatf("peak[%0d]", i), table_q[i].peak, peak);
        end
        finish_test("peak");
    endtask

    task automatic test_dac();
        dac_row_t table_q[$];
        int       count_l;
        int       count_r;
        table_q.push_back({16'sd0,     -16'sd16383, 32'd16384, 32'd1});
        table_q.push_back({16'sd16383, 16'sd1000,   32'd32767, 32'd17384});
        table_q.push_back({-16'sd8192, 16'sd0,      32'd8192,  32'd16384});
        foreach (table_q[i]) begin
            sound_l = table_q[i].l;
            sound_r = table_q[i].r;
            apply_reset();
            count_l = 0;
            count_r = 0;
            for (int c = 0; c < DAC_CYCLES; c++) begin
                @(negedge clk);
                count_l += int'(pdm_l);
                count_r += int'(pdm_r);
            end
            check_count($sformatf("dac[%0d] left", i), table_q[i].level_l, count_l);
            check_count($sformatf("dac[%0d] right", i), table_q[i].level_r, count_r);
        end
        finish_test("dac");
    endtask

    task automatic test_leds();
        led_row_t  table_q[$];
        pad_word_t pressed;
        int        count1;
        int        count2;
        pressed            = '1;
        pressed[PAD_START] = 1'b0;
        table_q.push_back({1'b0, 1'b1, 1'b1, 1'b0, 32'd0,      DIM_DUTY});
        table_q.push_back({1'b1, 1'b0, 1'b0, 1'b1, DIM_DUTY,   32'd0});
        table_q.push_back({1'b1, 1'b1, 1'b1, 1'b1, LED_PERIOD, LED_PERIOD});
        table_q.push_back({1'b1, 1'b0, 1'b1, 1'b0, DIM_DUTY,   DIM_DUTY});
        foreach (table_q[i]) begin
            strobe_pads(table_q[i].press1 ? pressed : '1, table_q[i].press2 ? pressed : '1,
                        table_q[i].c1, table_q[i].c2, 1'b0);
            count1 = 0;
            count2 = 0;
            for (int c = 0; c < LED_PERIOD; c++) begin
                count1 += int'(led_p1);
                count2 += int'(led_p2);
                @(negedge clk);
            end
            check_count($sformatf("led[%0d] p1", i), table_q[i].count1, count1);
            check_count($sformatf("led[%0d] p2", i), table_q[i].count2, count2);
        end
        finish_test("leds");
    endtask

    //--------------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------------

    initial begin
        reset          = 1'b1;
        pad_strobe     = 1'b0;
        p1_pad         = '1;
        p2_pad         = '1;
        p1_connect     = 1'b0;
        p2_connect     = 1'b0;
        pad_swap       = 1'b0;
        pointer_en     = 1'b0;
        pointer_coarse = 1'b0;
        sample_strobe  = 1'b0;
        sound_l        = '0;
        sound_r        = '0;
        apply_reset();
        test_remap();
        test_pointer();
        test_peak();
        test_dac();
        test_leds();
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+tests
hdl/console_io_pkg.sv
hdl/pwm_timer.sv
hdl/pad_router.sv
hdl/coord_pointer.sv
hdl/peak_meter.sv
hdl/pdm_dac.sv
hdl/console_io_top.sv
tests/tb_console_io.sv
